// File: common/qq_config.svh
`ifndef QQ_CONFIG_SVH
`define QQ_CONFIG_SVH

// Key width in bits
`define QQ_KEY_W 32

// Number of slots in the key RAM
`define QQ_DEPTH 16

// Slot index width, log2 of the depth
`define QQ_ADDR_W 4

// Cycles from a stable RAM address to valid read data
`define QQ_RD_LAT 2

`endif

// File: common/qq_pkg.sv
`default_nettype none

`include "qq_config.svh"

package qq_pkg;

  typedef logic [`QQ_KEY_W-1:0]  key_t;
  typedef logic [`QQ_ADDR_W-1:0] addr_t;
  typedef logic [`QQ_ADDR_W:0]   cnt_t;  // One extra bit so a full queue fits

  // Controller states
  typedef enum logic [3:0] {
    IDLE,
    FILL_ENQ,     // Load new key, restart index
    EMPTY_ENQ,    // Direct write of slot 0
    COMPARE_ENQ,
    SWAP_ENQ,
    CNT_INC,      // Step index up, restart read
    ENQ_BUFFER,   // Read wait of the upward walk
    TAIL_WRITE,
    DEQ_LOCATE,
    FILL_DEQ,     // Load sentinel, first read wait
    DEQ_SWAP,
    CNT_DEC,      // Step index down
    DEQ_DONE
  } qq_state_t;

  // Holding register action per cycle
  typedef enum logic [1:0] {
    VR_HOLD,
    VR_LOAD_IN,
    VR_LOAD_SENT,
    VR_SWAP
  } vr_mode_t;

endpackage

`default_nettype wire

// File: control/qq_control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module qq_control_fsm (
  input  logic             clk,
  input  logic             rst,
  input  logic             enq,
  input  logic             deq,
  input  logic             full,
  input  logic             empty,
  input  logic             at_tail,
  input  logic             wait_done,
  input  logic             lt,
  output qq_pkg::vr_mode_t vr_mode,
  output logic             ram_we,
  output logic             idx_clr,
  output logic             idx_ld_tail,
  output logic             idx_inc,
  output logic             idx_dec,
  output logic             cnt_inc,
  output logic             cnt_dec,
  output logic             wait_start,
  output logic             key_valid,
  output logic             busy
);

  import qq_pkg::*;

  qq_state_t state;
  qq_state_t next;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= next;
    end
  end

  assign busy = (state != IDLE);

  always_comb
  begin
    next        = state;
    vr_mode     = VR_HOLD;
    ram_we      = 1'b0;
    idx_clr     = 1'b0;
    idx_ld_tail = 1'b0;
    idx_inc     = 1'b0;
    idx_dec     = 1'b0;
    cnt_inc     = 1'b0;
    cnt_dec     = 1'b0;
    wait_start  = 1'b0;
    key_valid   = 1'b0;

    case (state)
      IDLE:
      begin
        // enq wins over deq, even when it is dropped for full
        if (enq)
        begin
          if (!full)
          begin
            next = FILL_ENQ;
          end
        end
        else if (deq && !empty)
        begin
          next = DEQ_LOCATE;
        end
      end

      ////////////////////////////////////////////////////////////
      // Enqueue, upward walk from slot 0
      ////////////////////////////////////////////////////////////
      FILL_ENQ:
      begin
        vr_mode    = VR_LOAD_IN;
        idx_clr    = 1'b1;
        wait_start = 1'b1;
        next       = empty ? EMPTY_ENQ : ENQ_BUFFER;
      end

      EMPTY_ENQ:
      begin
        ram_we  = 1'b1;   // Index already 0
        cnt_inc = 1'b1;
        next    = IDLE;
      end

      ENQ_BUFFER:
      begin
        if (at_tail)
        begin
          next = TAIL_WRITE;
        end
        else if (wait_done)
        begin
          next = COMPARE_ENQ;
        end
      end

      COMPARE_ENQ:
      begin
        next = lt ? SWAP_ENQ : CNT_INC;
      end

      SWAP_ENQ:
      begin
        // Held key into the slot, stored key into the register
        ram_we  = 1'b1;
        vr_mode = VR_SWAP;
        next    = CNT_INC;
      end

      CNT_INC:
      begin
        idx_inc    = 1'b1;
        wait_start = 1'b1;
        next       = ENQ_BUFFER;
      end

      TAIL_WRITE:
      begin
        ram_we  = 1'b1;
        cnt_inc = 1'b1;
        next    = IDLE;
      end

      ////////////////////////////////////////////////////////////
      // Dequeue, downward walk from the tail slot
      ////////////////////////////////////////////////////////////
      DEQ_LOCATE:
      begin
        idx_ld_tail = 1'b1;
        wait_start  = 1'b1;
        next        = FILL_DEQ;
      end

      FILL_DEQ:
      begin
        vr_mode = VR_LOAD_SENT;
        if (wait_done)
        begin
          next = DEQ_SWAP;
        end
      end

      DEQ_SWAP:
      begin
        if (wait_done)   // Read of the next lower slot
        begin
          ram_we  = 1'b1;
          vr_mode = VR_SWAP;
          next    = CNT_DEC;
        end
      end

      CNT_DEC:
      begin
        if (at_tail)
        begin
          next = DEQ_DONE;   // Slot 0 swapped, minimum is held
        end
        else
        begin
          idx_dec    = 1'b1;
          wait_start = 1'b1;
          next       = DEQ_SWAP;
        end
      end

      DEQ_DONE:
      begin
        key_valid = 1'b1;
        cnt_dec   = 1'b1;
        next      = IDLE;
      end

      default:
      begin
        next = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: datapath/qq_vector_reg.sv
`timescale 1ns/1ps
`default_nettype none

module qq_vector_reg (
  input  logic             clk,
  input  logic             rst,
  input  qq_pkg::vr_mode_t vr_mode,
  input  qq_pkg::key_t     key_in,
  input  qq_pkg::key_t     rd_data,
  output qq_pkg::key_t     held_key,
  output logic             lt
);

  import qq_pkg::*;

  // All ones fills a vacated slot, so no input key may take this value
  localparam key_t SENTINEL = '1;

  key_t held_next;

  ////////////////////////////////////////////////////////////
  // Source select
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    case (vr_mode)
      VR_LOAD_IN:   held_next = key_in;
      VR_LOAD_SENT: held_next = SENTINEL;
      VR_SWAP:      held_next = rd_data;   // Slot content moves into the register
      default:      held_next = held_key;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      held_key <= SENTINEL;
    end
    else
    begin
      held_key <= held_next;
    end
  end

  // Swap decision of the upward walk
  // Strict compare keeps equal keys in place
  assign lt = (held_key < rd_data);

endmodule

`default_nettype wire

// File: verilog/qq_key_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "qq_config.svh"

module qq_key_ram (
  input  logic          clk,
  input  logic          we,
  input  qq_pkg::addr_t addr,
  input  qq_pkg::key_t  wr_data,
  output qq_pkg::key_t  rd_data
);

  import qq_pkg::*;

  key_t mem [`QQ_DEPTH];
  key_t rd_q;   // First read stage

  // Write port
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[addr] <= wr_data;
    end
  end

  // Two read stages, old data on a same-slot write
  always_ff @(posedge clk)
  begin
    rd_q    <= mem[addr];
    rd_data <= rd_q;
  end

endmodule

`default_nettype wire

// File: verilog/qq_addr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "qq_config.svh"

module qq_addr_ctrl (
  input  logic          clk,
  input  logic          rst,
  input  logic          idx_clr,
  input  logic          idx_ld_tail,
  input  logic          idx_inc,
  input  logic          idx_dec,
  input  logic          cnt_inc,
  input  logic          cnt_dec,
  input  logic          wait_start,
  output qq_pkg::addr_t idx,
  output qq_pkg::cnt_t  count,
  output logic          full,
  output logic          empty,
  output logic          at_tail,
  output logic          wait_done
);

  import qq_pkg::*;

  localparam int WAIT_W = $clog2(`QQ_RD_LAT + 1);

  cnt_t              last_slot;
  logic              walk_down;   // Set by a tail load, cleared by an index clear
  logic [WAIT_W-1:0] wait_cnt;

  assign last_slot = count - cnt_t'(1);

  ////////////////////////////////////////////////////////////
  // Slot index
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idx       <= '0;
      walk_down <= 1'b0;
    end
    else if (idx_clr)
    begin
      idx       <= '0;
      walk_down <= 1'b0;
    end
    else if (idx_ld_tail)
    begin
      idx       <= last_slot[`QQ_ADDR_W-1:0];
      walk_down <= 1'b1;
    end
    else if (idx_inc)
    begin
      idx <= idx + addr_t'(1);
    end
    else if (idx_dec)
    begin
      idx <= idx - addr_t'(1);
    end
  end

  // Occupancy
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (cnt_inc && !full)
    begin
      count <= count + cnt_t'(1);
    end
    else if (cnt_dec && !empty)
    begin
      count <= count - cnt_t'(1);
    end
  end

  // Read latency timer, counts down from the edge that moves the index
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wait_cnt <= '0;
    end
    else if (wait_start)
    begin
      wait_cnt <= WAIT_W'(`QQ_RD_LAT);
    end
    else if (wait_cnt != '0)
    begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  assign wait_done = (wait_cnt == '0);   // Stays high until the next start
  assign full      = (count == cnt_t'(`QQ_DEPTH));
  assign empty     = (count == '0);

  // End of the walk in either direction
  assign at_tail = walk_down ? (idx == '0) : ({1'b0, idx} == count);

endmodule

`default_nettype wire

// File: verilog/quick_queue.sv
`timescale 1ns/1ps
`default_nettype none

module quick_queue (
  input  logic         clk,
  input  logic         rst,
  input  logic         enq,
  input  logic         deq,
  input  qq_pkg::key_t key_in,
  output qq_pkg::key_t key_out,
  output logic         key_valid,
  output logic         busy,
  output logic         full,
  output logic         empty,
  output qq_pkg::cnt_t count
);

  import qq_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////
  vr_mode_t vr_mode;
  logic     ram_we;
  logic     idx_clr;
  logic     idx_ld_tail;
  logic     idx_inc;
  logic     idx_dec;
  logic     cnt_inc;
  logic     cnt_dec;
  logic     wait_start;
  logic     at_tail;
  logic     wait_done;
  logic     lt;
  addr_t    idx;
  key_t     held_key;
  key_t     rd_data;

  assign key_out = held_key;   // Dequeued key after DEQ_DONE

  qq_control_fsm u_control_fsm (
    .clk         (clk),
    .rst         (rst),
    .enq         (enq),
    .deq         (deq),
    .full        (full),
    .empty       (empty),
    .at_tail     (at_tail),
    .wait_done   (wait_done),
    .lt          (lt),
    .vr_mode     (vr_mode),
    .ram_we      (ram_we),
    .idx_clr     (idx_clr),
    .idx_ld_tail (idx_ld_tail),
    .idx_inc     (idx_inc),
    .idx_dec     (idx_dec),
    .cnt_inc     (cnt_inc),
    .cnt_dec     (cnt_dec),
    .wait_start  (wait_start),
    .key_valid   (key_valid),
    .busy        (busy)
  );

  qq_addr_ctrl u_addr_ctrl (
    .clk         (clk),
    .rst         (rst),
    .idx_clr     (idx_clr),
    .idx_ld_tail (idx_ld_tail),
    .idx_inc     (idx_inc),
    .idx_dec     (idx_dec),
    .cnt_inc     (cnt_inc),
    .cnt_dec     (cnt_dec),
    .wait_start  (wait_start),
    .idx         (idx),
    .count       (count),
    .full        (full),
    .empty       (empty),
    .at_tail     (at_tail),
    .wait_done   (wait_done)
  );

  qq_vector_reg u_vector_reg (
    .clk      (clk),
    .rst      (rst),
    .vr_mode  (vr_mode),
    .key_in   (key_in),
    .rd_data  (rd_data),
    .held_key (held_key),
    .lt       (lt)
  );

  // Held key is always the write data
  qq_key_ram u_key_ram (
    .clk     (clk),
    .we      (ram_we),
    .addr    (idx),
    .wr_data (held_key),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: dv/quick_queue_properties.sv
`timescale 1ns/1ps
`default_nettype none

module quick_queue_properties (
  input logic              clk,
  input logic              rst,
  input qq_pkg::qq_state_t state,
  input logic              enq,
  input logic              deq,
  input logic              full,
  input logic              empty,
  input logic              key_valid,
  input logic              ram_we,
  input logic              busy
);

  import qq_pkg::*;

  ////////////////////////////////////////////////////////////
  // Output pulse rules
  ////////////////////////////////////////////////////////////
  a_valid_one_cycle : assert property (
    @(posedge clk) disable iff (rst) key_valid |=> !key_valid
  ) else $error("key_valid stayed high for more than one cycle");

  a_valid_in_done : assert property (
    @(posedge clk) disable iff (rst) key_valid |-> (state == DEQ_DONE)
  ) else $error("key_valid raised outside DEQ_DONE");

  // No RAM writes while waiting for a request
  a_no_write_idle : assert property (
    @(posedge clk) disable iff (rst) (state == IDLE) |-> !ram_we
  ) else $error("ram_we high in IDLE");

  // Accepted requests raise busy in the next cycle and dropped ones leave it low
  a_busy_accept : assert property (
    @(posedge clk) disable iff (rst)
      (state == IDLE) |=> (busy == $past(enq ? !full : (deq && !empty)))
  ) else $error("busy does not follow the request acceptance rules in IDLE");

  a_reset_idle : assert property (
    @(posedge clk) rst |=> (state == IDLE)
  ) else $error("reset did not return the controller to IDLE");

endmodule

bind qq_control_fsm quick_queue_properties u_properties (
  .clk       (clk),
  .rst       (rst),
  .state     (state),
  .enq       (enq),
  .deq       (deq),
  .full      (full),
  .empty     (empty),
  .key_valid (key_valid),
  .ram_we    (ram_we),
  .busy      (busy)
);

`default_nettype wire

// File: dv/quick_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "qq_config.svh"

module quick_queue_tb;

  import qq_pkg::*;

  localparam int CLK_HALF     = 4;   // 8 ns period
  localparam int RESET_CYCLES = 5;
  localparam int MAX_ENTRIES  = 32;
  localparam int OP_CYCLES    = `QQ_DEPTH * 8 + 20;   // Budget per queue operation
  localparam key_t ALL_ONES   = '1;   // Reserved as the vacated-slot marker, never a legal key

  typedef enum {OP_ENQ, OP_DEQ, OP_RAND, OP_BOTH} op_kind_t;

  logic clk;
  logic rst;
  logic enq;
  logic deq;
  key_t key_in;
  key_t key_out;
  logic key_valid;
  logic busy;
  logic full;
  logic empty;
  cnt_t count;

  // Stimulus table with the occupancy expected after each entry
  string    tab_name  [MAX_ENTRIES];
  op_kind_t tab_kind  [MAX_ENTRIES];
  key_t     tab_key   [MAX_ENTRIES];
  int       tab_reps  [MAX_ENTRIES];
  cnt_t     tab_count [MAX_ENTRIES];
  int       n_entries = 0;
  int       total_ops = 0;

  key_t model_q[$];   // Sorted reference queue, head is the minimum
  int   seed = 54035;

  quick_queue u_quick_queue (
    .clk       (clk),
    .rst       (rst),
    .enq       (enq),
    .deq       (deq),
    .key_in    (key_in),
    .key_out   (key_out),
    .key_valid (key_valid),
    .busy      (busy),
    .full      (full),
    .empty     (empty),
    .count     (count)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_key(input string name, input key_t exp, input key_t act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: expected key %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input cnt_t exp, input cnt_t act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: expected count %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input bit act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: expected %0b, actual %0b", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Table and reference model
  ////////////////////////////////////////////////////////////
  task automatic add_entry(input string name, input op_kind_t kind, input key_t key,
                           input int reps, input int exp_count);
    tab_name[n_entries]  = name;
    tab_kind[n_entries]  = kind;
    tab_key[n_entries]   = key;
    tab_reps[n_entries]  = reps;
    tab_count[n_entries] = cnt_t'(exp_count);
    n_entries++;
    total_ops += reps;
  endtask

  task automatic load_table();
    add_entry("deq_empty",       OP_DEQ,  32'h0000_0000,  1,  0);
    add_entry("single_enq",      OP_ENQ,  32'h1234_5678,  1,  1);
    add_entry("single_deq",      OP_DEQ,  32'h0000_0000,  1,  0);
    add_entry("rand_fill",       OP_RAND, 32'h0000_0000, 16, 16);
    add_entry("enq_full",        OP_ENQ,  32'h0000_0001,  1, 16);   // Dropped, queue full
    add_entry("both_full",       OP_BOTH, 32'h0000_0005,  1, 16);   // enq wins, then dropped
    add_entry("rand_drain",      OP_DEQ,  32'h0000_0000, 16,  0);
    add_entry("deq_empty_again", OP_DEQ,  32'h0000_0000,  1,  0);
    add_entry("dup_a",           OP_ENQ,  32'h0000_0100,  1,  1);
    add_entry("dup_lower",       OP_ENQ,  32'h0000_0050,  1,  2);
    add_entry("dup_b",           OP_ENQ,  32'h0000_0100,  1,  3);
    add_entry("dup_c",           OP_ENQ,  32'h0000_0100,  1,  4);
    add_entry("dup_drain",       OP_DEQ,  32'h0000_0000,  4,  0);
    add_entry("mix_enq_a",       OP_ENQ,  32'h8000_0000,  1,  1);
    add_entry("mix_enq_b",       OP_ENQ,  32'h0000_0040,  1,  2);
    add_entry("mix_deq_a",       OP_DEQ,  32'h0000_0000,  1,  1);
    add_entry("mix_enq_c",       OP_ENQ,  32'h0000_0010,  1,  2);   // Below the head
    add_entry("mix_enq_d",       OP_ENQ,  32'hFFFF_FFFE,  1,  3);
    add_entry("both_go",         OP_BOTH, 32'h0000_0001,  1,  4);
    add_entry("mix_deq_b",       OP_DEQ,  32'h0000_0000,  2,  2);
    add_entry("mix_rand",        OP_RAND, 32'h0000_0000,  6,  8);
    add_entry("mix_enq_zero",    OP_ENQ,  32'h0000_0000,  1,  9);
    add_entry("mix_drain",       OP_DEQ,  32'h0000_0000,  9,  0);
  endtask

  function automatic key_t random_key();
    key_t k;
    k = $random(seed);
    if (k == ALL_ONES)
    begin
      k[0] = 1'b0;   // Keep clear of the reserved value
    end
    return k;
  endfunction

  // Equal keys go behind the ones already queued
  task automatic model_insert(input key_t key);
    int pos;
    pos = 0;
    while (pos < model_q.size() && model_q[pos] <= key)
    begin
      pos++;
    end
    model_q.insert(pos, key);
  endtask

  ////////////////////////////////////////////////////////////
  // One request, called on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic run_op(input string name, input bit do_enq, input bit do_deq,
                        input key_t key);
    bit   take_enq;
    bit   take_deq;
    int   pulses;
    key_t got_key;
    key_t exp_key;
    pulses  = 0;
    got_key = '0;
    exp_key = '0;
    while (busy)
    begin
      @(negedge clk);
    end
    take_enq = do_enq && (model_q.size() < `QQ_DEPTH);
    take_deq = !do_enq && do_deq && (model_q.size() != 0);
    key_in = key;   // Held until the next request
    enq    = do_enq;
    deq    = do_deq;
    @(negedge clk);
    enq = 1'b0;
    deq = 1'b0;
    while (busy)
    begin
      if (key_valid)
      begin
        pulses++;
        got_key = key_out;
      end
      @(negedge clk);
    end

    if (take_enq)
    begin
      model_insert(key);
    end
    else if (take_deq)
    begin
      exp_key = model_q.pop_front();
    end

    if (take_deq && pulses == 0)
    begin
      $display("%s: dequeue of a non-empty queue ended without a key_valid pulse", name);
      abort_run();
    end
    if (!take_deq && pulses != 0)
    begin
      $display("%s: key_valid pulsed although no dequeue was performed", name);
      abort_run();
    end
    if (pulses > 1)
    begin
      $display("%s: key_valid pulsed %0d times in one dequeue", name, pulses);
      abort_run();
    end
    if (take_deq)
    begin
      check_key(name, exp_key, got_key);
    end
    check_count(name, cnt_t'(model_q.size()), count);
    check_flag({name, " empty"}, model_q.size() == 0, empty);
    check_flag({name, " full"}, model_q.size() == `QQ_DEPTH, full);
  endtask

  // Hang guard sized from the number of queue operations
  initial
  begin
    int limit;
    wait (total_ops > 0);
    limit = total_ops * OP_CYCLES + RESET_CYCLES + 20;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT did not finish its requests", limit);
    abort_run();
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    string op_name;
    rst    = 1'b1;
    enq    = 1'b0;
    deq    = 1'b0;
    key_in = '0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_count("reset count", '0, count);
    check_flag("reset empty", 1'b1, empty);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset key_valid", 1'b0, key_valid);

    for (int i = 0; i < n_entries; i++)
    begin
      for (int r = 0; r < tab_reps[i]; r++)
      begin
        op_name = $sformatf("%s[%0d]", tab_name[i], r);
        case (tab_kind[i])
          OP_ENQ:  run_op(op_name, 1'b1, 1'b0, tab_key[i]);
          OP_DEQ:  run_op(op_name, 1'b0, 1'b1, '0);
          OP_RAND: run_op(op_name, 1'b1, 1'b0, random_key());
          default: run_op(op_name, 1'b1, 1'b1, tab_key[i]);   // Both strobes together
        endcase
      end
      check_count({tab_name[i], " table"}, tab_count[i], count);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: quick_queue.f
+incdir+common
common/qq_pkg.sv
control/qq_control_fsm.sv
datapath/qq_vector_reg.sv
verilog/qq_key_ram.sv
verilog/qq_addr_ctrl.sv
verilog/quick_queue.sv
dv/quick_queue_properties.sv
dv/quick_queue_tb.sv

// File: Bender.yml
package:
  name: quick_queue

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/qq_pkg.sv
      - control/qq_control_fsm.sv
      - datapath/qq_vector_reg.sv
      - verilog/qq_key_ram.sv
      - verilog/qq_addr_ctrl.sv
      - verilog/quick_queue.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/quick_queue_properties.sv
      - dv/quick_queue_tb.sv
